// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_icache
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/icache_array.sv
module icache_array
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    input  logic [INDEX_W-1:0] rd_index,
    output logic               rd_valid,
    output logic [TAG_W-1:0]   rd_tag,
    output logic [DATA_W-1:0]  rd_data,

    input  logic               fill_en,
    input  logic [INDEX_W-1:0] fill_index,
    input  logic [TAG_W-1:0]   fill_tag,
    input  logic [DATA_W-1:0]  fill_data
);

    logic [LINES-1:0]  valid_q;
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [DATA_W-1:0] data_mem [LINES];

    // valid bits, flush takes priority over a fill
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            valid_q <= '0;
        end
        else if (fill_en)
        begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data;
        end
    end

    // lookup port, combinational
    always_comb
    begin
        rd_valid = valid_q[rd_index];
        rd_tag   = tag_mem[rd_index];
        rd_data  = data_mem[rd_index];
    end

endmodule

// File: hdl/icache_ctrl.sv
module icache_ctrl
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    // cpu side
    input  logic [ADDR_W-1:0]  cpu_req_addr,
    input  logic               cpu_req_valid,
    output logic [DATA_W-1:0]  cpu_req_data,
    output logic               cpu_req_ready,

    // array lookup
    output logic [INDEX_W-1:0] rd_index,
    input  logic               rd_valid,
    input  logic [TAG_W-1:0]   rd_tag,
    input  logic [DATA_W-1:0]  rd_data,

    // array fill
    output logic               fill_en,
    output logic [INDEX_W-1:0] fill_index,
    output logic [TAG_W-1:0]   fill_tag,
    output logic [DATA_W-1:0]  fill_data,

    // memory side
    output logic [ADDR_W-1:0]  mem_req_addr,
    output logic               mem_req_valid,
    input  logic [DATA_W-1:0]  mem_req_data,
    input  logic               mem_req_ready,

    output logic [CNT_W-1:0]   hit_count,
    output logic [CNT_W-1:0]   miss_count
);

    ctrl_state_t state, state_next;

    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;
    logic               hit;
    logic               refill;

    assign req_tag   = cpu_req_addr[ADDR_W-1 -: TAG_W];
    assign req_index = cpu_req_addr[OFFS_W +: INDEX_W];

    assign rd_index = req_index;
    assign hit      = rd_valid && (rd_tag == req_tag);

    // answer straight from the array in the lookup cycle
    assign cpu_req_ready = (state == LOOKUP) && hit;
    assign cpu_req_data  = rd_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:     state_next = cpu_req_valid ? LOOKUP : IDLE;
            LOOKUP:   state_next = hit ? IDLE : ALLOCATE;
            ALLOCATE: state_next = mem_req_ready ? LOOKUP : ALLOCATE;
            default:  state_next = IDLE;
        endcase
    end

    // memory request, up from allocate entry until the response
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (state == LOOKUP && !hit)
        begin
            mem_req_valid <= 1'b1;
        end
        else if (state == ALLOCATE && mem_req_ready)
        begin
            mem_req_valid <= 1'b0;
        end
    end

    // word-aligned line address, held for the whole miss
    always_ff @(posedge clk)
    begin
        if (state == LOOKUP && !hit)
        begin
            mem_req_addr <= {req_tag, req_index, {OFFS_W{1'b0}}};
        end
    end

    assign fill_en    = (state == ALLOCATE) && mem_req_ready;
    assign fill_index = mem_req_addr[OFFS_W +: INDEX_W];
    assign fill_tag   = mem_req_addr[ADDR_W-1 -: TAG_W];
    assign fill_data  = mem_req_data;

    // lookup after a fill belongs to the miss already counted
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            refill <= 1'b0;
        end
        else if (fill_en)
        begin
            refill <= 1'b1;
        end
        else if (state == LOOKUP)
        begin
            refill <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else if (state == LOOKUP)
        begin
            if (!hit)
            begin
                miss_count <= miss_count + 1'b1;
            end
            else if (!refill)
            begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

endmodule

// File: hdl/icache_pkg.sv
package icache_pkg;

    // address split: tag | index | byte offset
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int OFFS_W  = 2;
    localparam int INDEX_W = 4;
    localparam int LINES   = 1 << INDEX_W;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFS_W;

    // backing memory, word addressed from bits 11..2
    localparam int MEM_AW    = 10;
    localparam int MEM_WORDS = 1 << MEM_AW;

    // wait cycles between request and response
    localparam int MEM_LAT = 3;
    localparam int LAT_W   = $clog2(MEM_LAT + 1);

    // statistics
    localparam int CNT_W = 16;

    typedef enum logic [1:0]
    {
        IDLE,
        LOOKUP,
        ALLOCATE
    } ctrl_state_t;

endpackage

// File: hdl/icache_top.sv
module icache_top
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [ADDR_W-1:0] cpu_req_addr,
    input  logic              cpu_req_valid,
    output logic [DATA_W-1:0] cpu_req_data,
    output logic              cpu_req_ready,

    input  logic              flush,

    input  logic              prog_we,
    input  logic [MEM_AW-1:0] prog_addr,
    input  logic [DATA_W-1:0] prog_data,

    output logic [CNT_W-1:0]  hit_count,
    output logic [CNT_W-1:0]  miss_count
);

    logic [INDEX_W-1:0] rd_index;
    logic               rd_valid;
    logic [TAG_W-1:0]   rd_tag;
    logic [DATA_W-1:0]  rd_data;

    logic               fill_en;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    logic [DATA_W-1:0]  fill_data;

    logic [ADDR_W-1:0]  mem_req_addr;
    logic               mem_req_valid;
    logic [DATA_W-1:0]  mem_req_data;
    logic               mem_req_ready;

    icache_ctrl u_ctrl
    (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .rd_index      (rd_index),
        .rd_valid      (rd_valid),
        .rd_tag        (rd_tag),
        .rd_data       (rd_data),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_data     (fill_data),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    icache_array u_array
    (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .rd_index   (rd_index),
        .rd_valid   (rd_valid),
        .rd_tag     (rd_tag),
        .rd_data    (rd_data),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_data  (fill_data)
    );

    instr_mem u_mem
    (
        .clk       (clk),
        .rst       (rst),
        .req_addr  (mem_req_addr),
        .req_valid (mem_req_valid),
        .rsp_data  (mem_req_data),
        .rsp_ready (mem_req_ready),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

// File: hdl/instr_mem.sv
module instr_mem
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [ADDR_W-1:0] req_addr,
    input  logic              req_valid,
    output logic [DATA_W-1:0] rsp_data,
    output logic              rsp_ready,

    input  logic              prog_we,
    input  logic [MEM_AW-1:0] prog_addr,
    input  logic [DATA_W-1:0] prog_data
);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic [MEM_AW-1:0] word_addr;
    logic [LAT_W-1:0]  wait_cnt;
    logic              busy;
    logic              wait_drop;
    logic              respond;

    // upper address bits alias onto the same words
    assign word_addr = req_addr[OFFS_W +: MEM_AW];
    assign respond   = busy && (wait_cnt == '0);

    // load port, independent of any read in flight
    always_ff @(posedge clk)
    begin
        if (prog_we)
        begin
            mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            wait_drop <= 1'b0;
            rsp_ready <= 1'b0;
        end
        else
        begin
            rsp_ready <= respond;
            if (respond)
            begin
                busy      <= 1'b0;
                wait_drop <= 1'b1;
            end
            else if (busy)
            begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            else if (wait_drop)
            begin
                // rearm once the requester lets go
                wait_drop <= req_valid;
            end
            else if (req_valid)
            begin
                busy     <= 1'b1;
                wait_cnt <= LAT_W'(MEM_LAT);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (respond)
        begin
            rsp_data <= mem[word_addr];
        end
    end

endmodule

// File: src.f
hdl/icache_pkg.sv
hdl/icache_array.sv
hdl/icache_ctrl.sv
hdl/instr_mem.sv
hdl/icache_top.sv
tb/icache_chk.sv
tb/tb_icache.sv

// File: tb/icache_chk.sv
module icache_chk
    import icache_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input ctrl_state_t        state,
    input logic [ADDR_W-1:0]  cpu_req_addr,
    input logic               cpu_req_ready,
    input logic               fill_en,
    input logic [INDEX_W-1:0] fill_index,
    input logic [TAG_W-1:0]   fill_tag,
    input logic               mem_req_valid,
    input logic               mem_req_ready
);

    // tags as last written by fills; flush only clears, so a superset
    logic [LINES-1:0]   filled;
    logic [TAG_W-1:0]   filled_tag [LINES];
    logic [INDEX_W-1:0] req_index;
    logic               tag_match;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            filled <= '0;
        end
        else if (fill_en)
        begin
            filled[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            filled_tag[fill_index] <= fill_tag;
        end
    end

    assign req_index = cpu_req_addr[OFFS_W +: INDEX_W];
    assign tag_match = filled[req_index]
        && (filled_tag[req_index] == cpu_req_addr[ADDR_W-1 -: TAG_W]);

    mem_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid)
        else $error("mem_req_valid dropped before mem_req_ready");

    // ready only out of a lookup that hits
    ready_on_hit: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |-> (state == LOOKUP) && tag_match)
        else $error("cpu_req_ready outside a LOOKUP hit");

    ready_single: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |=> !cpu_req_ready)
        else $error("cpu_req_ready high for two cycles");

    reset_quiet: assert property (@(posedge clk)
        rst |=> !cpu_req_ready && !mem_req_valid)
        else $error("handshake outputs not low after reset");

endmodule

bind icache_ctrl icache_chk u_chk
(
    .clk           (clk),
    .rst           (rst),
    .state         (state),
    .cpu_req_addr  (cpu_req_addr),
    .cpu_req_ready (cpu_req_ready),
    .fill_en       (fill_en),
    .fill_index    (fill_index),
    .fill_tag      (fill_tag),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready)
);

// File: tb/tb_icache.sv
module tb_icache
    import icache_pkg::*;
();

    localparam int FETCHES = 250;
    localparam int POOL    = 12;
    localparam int TIMEOUT = FETCHES * (MEM_LAT + 8) + 2 * MEM_WORDS + 500;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] cpu_req_addr;
    logic              cpu_req_valid;
    logic [DATA_W-1:0] cpu_req_data;
    logic              cpu_req_ready;
    logic              flush;
    logic              prog_we;
    logic [MEM_AW-1:0] prog_addr;
    logic [DATA_W-1:0] prog_data;
    logic [CNT_W-1:0]  hit_count;
    logic [CNT_W-1:0]  miss_count;

    // reference model: memory as loaded, lines as the cache should hold them
    logic [DATA_W-1:0] mem_model [MEM_WORDS];
    logic              line_valid [LINES];
    logic [TAG_W-1:0]  line_tag [LINES];
    logic [DATA_W-1:0] line_data [LINES];
    logic [CNT_W-1:0]  exp_hits;
    logic [CNT_W-1:0]  exp_misses;

    integer seed = 86;
    int     cycles = 0;

    icache_top dut
    (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .flush         (flush),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT)
        begin
            $display("timeout after %0d cycles, the tests did not complete", cycles);
            abort_run();
        end
    end

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // pattern depends on every bit of the word address
    function automatic logic [DATA_W-1:0] fill_word(input logic [MEM_AW-1:0] a);
        return {~a[5:0], a, 6'h15, a};
    endfunction

    task automatic load_word(input logic [MEM_AW-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        #1;
        prog_we   = 1'b1;
        prog_addr = a;
        prog_data = d;
        mem_model[a] = d;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic do_flush();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int i = 0; i < LINES; i++)
        begin
            line_valid[i] = 1'b0;
        end
    endtask

    task automatic fetch(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        #1;
        cpu_req_addr  = addr;
        cpu_req_valid = 1'b1;
        do
        begin
            @(negedge clk);
        end
        while (!cpu_req_ready);
        data = cpu_req_data;
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
    endtask

    task automatic fetch_and_check(input logic [ADDR_W-1:0] addr,
                                   output logic [DATA_W-1:0] got);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic [DATA_W-1:0]  exp;
        idx = addr[OFFS_W +: INDEX_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        if (line_valid[idx] && line_tag[idx] == tag)
        begin
            exp      = line_data[idx];
            exp_hits = exp_hits + 1'b1;
        end
        else
        begin
            exp            = mem_model[addr[OFFS_W +: MEM_AW]];
            line_valid[idx] = 1'b1;
            line_tag[idx]  = tag;
            line_data[idx] = exp;
            exp_misses     = exp_misses + 1'b1;
        end
        fetch(addr, got);
        check_data("cpu_req_data", got, exp);
        check_count("hit_count", hit_count, exp_hits);
        check_count("miss_count", miss_count, exp_misses);
    endtask

    task automatic test_cold_miss_hit();
        logic [DATA_W-1:0] got;
        fetch_and_check(32'h0000_0040, got);
        check_data("cpu_req_data", got, fill_word(10'h010));
        check_count("miss_count", miss_count, CNT_W'(1));
        check_count("hit_count", hit_count, CNT_W'(0));
        fetch_and_check(32'h0000_0040, got);
        check_data("cpu_req_data", got, fill_word(10'h010));
        check_count("miss_count", miss_count, CNT_W'(1));
        check_count("hit_count", hit_count, CNT_W'(1));
    endtask

    task automatic test_conflict();
        logic [DATA_W-1:0] got_x;
        logic [DATA_W-1:0] got_y;
        logic [DATA_W-1:0] got_z;
        logic [CNT_W-1:0]  h0;
        logic [CNT_W-1:0]  m0;
        h0 = hit_count;
        m0 = miss_count;
        // all on index 5, z aliases x in memory
        repeat (2)
        begin
            fetch_and_check(32'h0000_0114, got_x);
            fetch_and_check(32'h0000_0214, got_y);
            fetch_and_check(32'h0001_0114, got_z);
            check_data("cpu_req_data", got_z, got_x);
        end
        check_count("miss_count", miss_count - m0, CNT_W'(6));
        check_count("hit_count", hit_count, h0);
    endtask

    task automatic test_stale_until_flush();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] old;
        fetch_and_check(32'h0000_0088, got);
        old = got;
        load_word(10'h022, ~old);
        fetch_and_check(32'h0000_0088, got);
        check_data("cpu_req_data", got, old);
        do_flush();
        fetch_and_check(32'h0000_0088, got);
        check_data("cpu_req_data", got, ~old);
    endtask

    task automatic test_all_lines();
        logic [DATA_W-1:0] got;
        logic [CNT_W-1:0]  h0;
        logic [CNT_W-1:0]  m0;
        do_flush();
        h0 = hit_count;
        m0 = miss_count;
        repeat (2)
        begin
            for (int i = 0; i < LINES; i++)
            begin
                fetch_and_check(ADDR_W'(32'h400 + i * 4), got);
            end
        end
        check_count("miss_count", miss_count - m0, CNT_W'(16));
        check_count("hit_count", hit_count - h0, CNT_W'(16));
    endtask

    task automatic test_random_stream();
        logic [ADDR_W-1:0] pool [POOL];
        logic [DATA_W-1:0] got;
        logic [31:0]       r;
        logic [CNT_W-1:0]  n0;
        int                k;
        do_flush();
        n0 = hit_count + miss_count;
        // small tag range and eight indexes, so lines conflict
        for (int i = 0; i < POOL; i++)
        begin
            r = $random(seed);
            pool[i] = {r[31:12] & 20'h3, r[11:6], 1'b0, r[4:2], 2'b00};
            load_word(pool[i][OFFS_W +: MEM_AW], DATA_W'($random(seed)));
        end
        repeat (200)
        begin
            r = $random(seed);
            k = int'(r[7:0]) % POOL;
            if (r[12:9] == 4'h0)
            begin
                load_word(pool[k][OFFS_W +: MEM_AW], DATA_W'($random(seed)));
            end
            fetch_and_check(pool[k], got);
        end
        check_count("hit_count + miss_count", hit_count + miss_count - n0, CNT_W'(200));
    endtask

    initial
    begin
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        flush         = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        exp_hits      = '0;
        exp_misses    = '0;
        for (int i = 0; i < LINES; i++)
        begin
            line_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_count("hit_count", hit_count, CNT_W'(0));
        check_count("miss_count", miss_count, CNT_W'(0));
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            load_word(MEM_AW'(a), fill_word(MEM_AW'(a)));
        end

        test_cold_miss_hit();
        test_conflict();
        test_stale_until_flush();
        test_all_lines();
        test_random_stream();

        $display("TB PASSED");
        $finish;
    end

endmodule
